// File: hdl/vit_trellis_pkg.sv
/*
  trellis of the rate 1/2, K=3 convolutional code, generators 7 and 5 octal
  state is {u[n-1], u[n-2]}, so the state MSB is the most recent input bit
*/

package vit_trellis_pkg;

  //--------------------------------------------------------------------------
  // code geometry
  //--------------------------------------------------------------------------

  localparam int cSTATE_NUM  = 4;
  localparam int cSTATE_W    = 2;
  localparam int cBRANCH_NUM = 2;
  // code bits per symbol, symbol = {g7 bit, g5 bit}
  localparam int cCODE_W     = 2;
  // zero tail drives the encoder back to state 0
  localparam int cTAIL_LEN   = 2;

  //--------------------------------------------------------------------------
  // transition tables indexed [current state][input bit]
  //--------------------------------------------------------------------------

  // next state = {u, state[1]}
  localparam logic [cSTATE_W-1:0] cNEXT_STATE [cSTATE_NUM][cBRANCH_NUM] = '{
    '{2'd0, 2'd2},
    '{2'd0, 2'd2},
    '{2'd1, 2'd3},
    '{2'd1, 2'd3}
  };

  // g7 bit = u ^ s1 ^ s0 in the MSB, g5 bit = u ^ s0 in the LSB
  localparam logic [cCODE_W-1:0] cOUTPUT [cSTATE_NUM][cBRANCH_NUM] = '{
    '{2'd0, 2'd3},
    '{2'd3, 2'd0},
    '{2'd2, 2'd1},
    '{2'd1, 2'd2}
  };

endpackage

// File: hdl/vit_dec_pkg.sv
/*
  viterbi decoder datapath definitions
  soft input widths, metric words, decision vector and traceback FSM states
*/

package vit_dec_pkg;

  //--------------------------------------------------------------------------
  // widths and limits
  //--------------------------------------------------------------------------

  // offset binary soft bit, 0 = sure zero, 7 = sure one
  localparam int cSOFT_W    = 3;
  // two soft distances, max 14
  localparam int cBM_W      = 4;
  // wrapping path metric, modulo 128
  localparam int cSTATEM_W  = 7;
  localparam int cFRAME_MAX = 64;
  localparam int cADDR_W    = $clog2(cFRAME_MAX);

  // penalty for states other than 0 at sop
  // quarter range keeps the wrapped compare unambiguous
  localparam int cSTATEM_INIT = 2**(cSTATEM_W-2);

  //--------------------------------------------------------------------------
  // types
  //--------------------------------------------------------------------------

  typedef logic [cSOFT_W-1:0]                          soft_t;
  // [1] carries the g7 soft bit, [0] the g5 soft bit
  typedef soft_t [vit_trellis_pkg::cCODE_W-1:0]         symb_t;

  typedef logic [cBM_W-1:0]                            bm_word_t;
  // one metric per hypothesis code symbol
  typedef bm_word_t [2**vit_trellis_pkg::cCODE_W-1:0]   bm_t;

  typedef logic [cSTATEM_W-1:0]                        pm_t;
  typedef pm_t [vit_trellis_pkg::cSTATE_NUM-1:0]        statem_t;

  // bit per state, 1 = survivor came from the predecessor with LSB 1
  typedef logic [vit_trellis_pkg::cSTATE_NUM-1:0]       decision_t;

  typedef logic [cADDR_W-1:0]                          addr_t;

  typedef enum logic [1:0] {IDLE, FILL, TRACE, REPLAY} tb_state_e;

endpackage

// File: hdl/vit_bm_if.sv
/*
  branch metric link from the metric unit to the recursive processor
*/

`timescale 1ns/1ps

interface vit_bm_if;

  // framing strobes, qualified by val
  logic              sop;
  logic              val;
  logic              eop;
  // four hypothesis distances
  vit_dec_pkg::bm_t  bm;

  // metric unit side
  modport src (output sop, val, eop, bm);

  // recursive processor side
  modport snk (input sop, val, eop, bm);

endinterface

// File: hdl/vit_dec_bmu.sv
/*
  branch metric unit
  turns one soft symbol into the distances to all four code symbols,
  registered together with the framing strobes
*/

`timescale 1ns/1ps

module vit_dec_bmu (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  input  logic               isop,
  input  logic               ival,
  input  logic               ieop,
  input  vit_dec_pkg::symb_t isymb,
  vit_bm_if.src              bm
);

  vit_dec_pkg::bm_t bm_comb;

  // distance of a soft bit to the ideal 0 or 7
  function automatic vit_dec_pkg::bm_word_t soft_dist(input vit_dec_pkg::soft_t s,
                                                      input logic hyp);
    vit_dec_pkg::soft_t d;
    // for a 3 bit offset value, 7 - s is just ~s at soft width
    d         = hyp ? ~s : s;
    soft_dist = vit_dec_pkg::bm_word_t'(d);
  endfunction

  //--------------------------------------------------------------------------
  // hypothesis metrics
  //--------------------------------------------------------------------------

  always_comb begin
    for (int c = 0; c < 2**vit_trellis_pkg::cCODE_W; c++) begin
      // c[1] is the g7 hypothesis, c[0] the g5 one
      bm_comb[c] = soft_dist(isymb[1], c[1]) + soft_dist(isymb[0], c[0]);
    end
  end

  //--------------------------------------------------------------------------
  // output register
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      bm.val <= 1'b0;
    end else if (iclkena) begin
      bm.val <= ival;
    end
  end

  // strobes and metrics only matter while val is high
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      bm.sop <= isop;
      bm.eop <= ieop;
      bm.bm  <= bm_comb;
    end
  end

endmodule

// File: hdl/vit_dec_acsu.sv
/*
  add-compare-select engine for one trellis state
  path metrics wrap, the smaller one is found by the sign of the difference
*/

`timescale 1ns/1ps

module vit_dec_acsu (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 iclkena,
  input  logic                 ival,
  // index = LSB of the predecessor state
  input  vit_dec_pkg::bm_word_t [vit_trellis_pkg::cBRANCH_NUM-1:0] ibm,
  input  vit_dec_pkg::pm_t      [vit_trellis_pkg::cBRANCH_NUM-1:0] istatem,
  output vit_dec_pkg::pm_t     ostatem,
  output logic                 odecision
);

  vit_dec_pkg::pm_t sum0;
  vit_dec_pkg::pm_t sum1;
  vit_dec_pkg::pm_t diff;
  logic             sel;

  // add, branch metric zero extended into the path metric width
  assign sum0 = istatem[0] + vit_dec_pkg::pm_t'(ibm[0]);
  assign sum1 = istatem[1] + vit_dec_pkg::pm_t'(ibm[1]);

  // compare on the circle, negative difference means sum1 is smaller
  assign diff = sum1 - sum0;
  assign sel  = diff[vit_dec_pkg::cSTATEM_W-1];

  // select
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ostatem <= '0;
    end else if (iclkena && ival) begin
      ostatem <= sel ? sum1 : sum0;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      odecision <= sel;
    end
  end

endmodule

// File: hdl/vit_dec_rp.sv
/*
  recursive processor, one ACS engine per trellis state
  routes predecessor and branch metrics through the code tables and
  restarts the metrics at sop so that decoding begins in state 0
*/

`timescale 1ns/1ps

module vit_dec_rp #(
  // keep the previous frame's metrics at sop
  parameter bit pSOP_STATE_SYNC_DISABLE = 1'b0
) (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  vit_bm_if.snk                  bm,
  output logic                   osop,
  output logic                   oval,
  output logic                   oeop,
  output vit_dec_pkg::statem_t   ostatem,
  output vit_dec_pkg::decision_t odecision
);

  // engine inputs, [next state][branch]
  vit_dec_pkg::bm_word_t [vit_trellis_pkg::cBRANCH_NUM-1:0] acsu_bm
    [vit_trellis_pkg::cSTATE_NUM];
  vit_dec_pkg::pm_t      [vit_trellis_pkg::cBRANCH_NUM-1:0] acsu_statem
    [vit_trellis_pkg::cSTATE_NUM];
  // predecessor metrics after the sop restart
  vit_dec_pkg::pm_t pred_statem [vit_trellis_pkg::cSTATE_NUM];

  //--------------------------------------------------------------------------
  // sop restart
  //--------------------------------------------------------------------------

  always_comb begin
    for (int s = 0; s < vit_trellis_pkg::cSTATE_NUM; s++) begin
      pred_statem[s] = ostatem[s];
      if (bm.sop && !pSOP_STATE_SYNC_DISABLE) begin
        // state 0 starts ahead, all others carry a penalty
        pred_statem[s] = (s == 0) ? '0 : vit_dec_pkg::pm_t'(vit_dec_pkg::cSTATEM_INIT);
      end
    end
  end

  //--------------------------------------------------------------------------
  // trellis routing
  //--------------------------------------------------------------------------

  always_comb begin
    logic [vit_trellis_pkg::cSTATE_W-1:0] ns;
    acsu_bm     = '{default: '0};
    acsu_statem = '{default: '0};
    ns          = '0;
    for (int ps = 0; ps < vit_trellis_pkg::cSTATE_NUM; ps++) begin
      for (int u = 0; u < vit_trellis_pkg::cBRANCH_NUM; u++) begin
        ns = vit_trellis_pkg::cNEXT_STATE[ps][u];
        // both predecessors of ns differ only in their LSB
        acsu_statem[ns][ps[0]] = pred_statem[ps];
        acsu_bm[ns][ps[0]]     = bm.bm[vit_trellis_pkg::cOUTPUT[ps][u]];
      end
    end
  end

  //--------------------------------------------------------------------------
  // engines
  //--------------------------------------------------------------------------

  for (genvar gs = 0; gs < vit_trellis_pkg::cSTATE_NUM; gs++) begin : acsu_gen
    vit_dec_acsu acsu (
      .iclk      (iclk),
      .ireset    (ireset),
      .iclkena   (iclkena),
      .ival      (bm.val),
      .ibm       (acsu_bm[gs]),
      .istatem   (acsu_statem[gs]),
      .ostatem   (ostatem[gs]),
      .odecision (odecision[gs])
    );
  end

  // strobes follow the engines by one cycle
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= bm.val;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      osop <= bm.sop & bm.val;
      oeop <= bm.eop & bm.val;
    end
  end

endmodule

// File: hdl/vit_dec_tbu.sv
/*
  traceback unit
  stores decision vectors, walks back from state 0 after eop and then
  replays the decoded bits in forward order without the tail
*/

`timescale 1ns/1ps

module vit_dec_tbu (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  logic                   isop,
  input  logic                   ival,
  input  logic                   ieop,
  input  vit_dec_pkg::decision_t idecision,
  output logic                   osop,
  output logic                   oval,
  output logic                   oeop,
  output logic                   odat,
  output logic                   obusy
);

  vit_dec_pkg::tb_state_e state;

  // decision memory, one word per trellis step
  vit_dec_pkg::decision_t dec_mem [vit_dec_pkg::cFRAME_MAX];
  // decoded bits in trellis order
  logic [vit_dec_pkg::cFRAME_MAX-1:0] bit_buf;

  vit_dec_pkg::addr_t wr_ptr;
  vit_dec_pkg::addr_t wr_addr;
  vit_dec_pkg::addr_t rd_addr;
  vit_dec_pkg::addr_t last_addr;
  vit_dec_pkg::addr_t rep_last;
  logic               wr_ena;

  // trellis state during the walk back
  logic [vit_trellis_pkg::cSTATE_W-1:0] tb_state;
  logic                                 dec_bit;

  logic oval_r;
  logic osop_r;
  logic oeop_r;

  //--------------------------------------------------------------------------
  // addressing
  //--------------------------------------------------------------------------

  // writes start on sop in IDLE and continue until eop
  assign wr_ena  = ival & (((state == vit_dec_pkg::IDLE) & isop) |
                           (state == vit_dec_pkg::FILL));
  assign wr_addr = isop ? '0 : wr_ptr;

  // last data bit sits just before the tail
  assign rep_last = last_addr - vit_dec_pkg::addr_t'(vit_trellis_pkg::cTAIL_LEN);

  // survivor bit of the current state at the current step
  assign dec_bit = dec_mem[rd_addr][tb_state];

  //--------------------------------------------------------------------------
  // memories and output data
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr_ena) begin
        dec_mem[wr_addr] <= idecision;
      end
      // input bit of a step is the MSB of the state it leads to
      if (state == vit_dec_pkg::TRACE) begin
        bit_buf[rd_addr] <= tb_state[vit_trellis_pkg::cSTATE_W-1];
      end
      if (state == vit_dec_pkg::REPLAY) begin
        odat <= bit_buf[rd_addr];
      end
    end
  end

  //--------------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= vit_dec_pkg::IDLE;
      wr_ptr    <= '0;
      rd_addr   <= '0;
      last_addr <= '0;
      tb_state  <= '0;
      oval_r    <= 1'b0;
      osop_r    <= 1'b0;
      oeop_r    <= 1'b0;
    end else if (iclkena) begin
      oval_r <= 1'b0;
      osop_r <= 1'b0;
      oeop_r <= 1'b0;
      case (state)
        vit_dec_pkg::IDLE, vit_dec_pkg::FILL: begin
          if (wr_ena) begin
            wr_ptr <= wr_addr + 1'b1;
            state  <= vit_dec_pkg::FILL;
            // frame closed, trellis is known to end in state 0
            if (ieop) begin
              last_addr <= wr_addr;
              rd_addr   <= wr_addr;
              tb_state  <= '0;
              state     <= vit_dec_pkg::TRACE;
            end
          end
        end
        vit_dec_pkg::TRACE: begin
          // predecessor = {state LSB, stored decision}
          tb_state <= {tb_state[vit_trellis_pkg::cSTATE_W-2:0], dec_bit};
          if (rd_addr == '0) begin
            state <= vit_dec_pkg::REPLAY;
          end else begin
            rd_addr <= rd_addr - 1'b1;
          end
        end
        vit_dec_pkg::REPLAY: begin
          oval_r  <= 1'b1;
          osop_r  <= (rd_addr == '0);
          oeop_r  <= (rd_addr == rep_last);
          rd_addr <= rd_addr + 1'b1;
          if (rd_addr == rep_last) begin
            state <= vit_dec_pkg::IDLE;
          end
        end
        default: begin
          state <= vit_dec_pkg::IDLE;
        end
      endcase
    end
  end

  // strobes only show on enabled cycles, so each bit is seen once
  assign oval = oval_r & iclkena;
  assign osop = osop_r & iclkena;
  assign oeop = oeop_r & iclkena;

  // busy from the sop reaching this unit until the last bit is taken
  assign obusy = (state != vit_dec_pkg::IDLE) | oeop_r;

endmodule

// File: hdl/vit_dec.sv
/*
  hard-framed viterbi decoder, rate 1/2 K=3 code
  metric unit -> recursive processor -> traceback unit
*/

`timescale 1ns/1ps

module vit_dec #(
  parameter bit pSOP_STATE_SYNC_DISABLE = 1'b0
) (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  input  logic               isop,
  input  logic               ival,
  input  logic               ieop,
  input  vit_dec_pkg::symb_t isymb,
  output logic               osop,
  output logic               oval,
  output logic               oeop,
  output logic               odat,
  output logic               obusy
);

  //--------------------------------------------------------------------------
  // internal links
  //--------------------------------------------------------------------------

  vit_bm_if bm_if ();

  // recursive processor to traceback
  logic                   rp_sop;
  logic                   rp_val;
  logic                   rp_eop;
  vit_dec_pkg::decision_t rp_decision;

  //--------------------------------------------------------------------------
  // stages
  //--------------------------------------------------------------------------

  vit_dec_bmu bmu (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .isop    (isop),
    .ival    (ival),
    .ieop    (ieop),
    .isymb   (isymb),
    .bm      (bm_if)
  );

  // path metrics stay inside, traceback always starts from state 0
  vit_dec_rp #(
    .pSOP_STATE_SYNC_DISABLE (pSOP_STATE_SYNC_DISABLE)
  ) rp (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .bm        (bm_if),
    .osop      (rp_sop),
    .oval      (rp_val),
    .oeop      (rp_eop),
    .ostatem   (),
    .odecision (rp_decision)
  );

  vit_dec_tbu tbu (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .isop      (rp_sop),
    .ival      (rp_val),
    .ieop      (rp_eop),
    .idecision (rp_decision),
    .osop      (osop),
    .oval      (oval),
    .oeop      (oeop),
    .odat      (odat),
    .obusy     (obusy)
  );

endmodule

// File: tests/vit_dec_tb.sv
/*
  testbench for the hard-framed viterbi decoder
  random frames through an encoder model, with errors, noise and stalls
*/

`timescale 1ns/1ps

module vit_dec_tb;

  localparam int CLK_HALF   = 4;
  localparam int RST_CYCLES = 16;
  localparam int FRAME_MAX  = 64;
  localparam int TAIL_LEN   = 2;
  // frames per test phase, six phases
  localparam int PHASE_FRAMES = 6;
  localparam int FRAME_CNT    = 6 * PHASE_FRAMES;
  // output wait limit per frame, in cycles
  localparam int FRAME_WAIT   = 4 * FRAME_MAX + 64;
  // three cycles per symbol plus slack per frame for stalls
  localparam int WATCHDOG_CYCLES = FRAME_CNT * (3 * FRAME_MAX + 64) + 1000;
  // unframed symbols ahead of each sop
  localparam int PRE_SYMS     = 3;

  // noise modes
  localparam int MODE_FLIP  = 1;
  localparam int MODE_NOISE = 2;

  logic               iclk;
  logic               ireset;
  logic               iclkena;
  logic               isop;
  logic               ival;
  logic               ieop;
  vit_dec_pkg::symb_t isymb;
  logic               osop;
  logic               oval;
  logic               oeop;
  logic               odat;
  logic               obusy;

  logic [15:0] lfsr;
  logic        stall_on;
  logic        run_checks;
  logic        exp_q [$];
  logic [5:0]  frame_sym [FRAME_MAX];
  int          frame_bits;
  int          out_cnt;
  int          frame_idx;
  int          bits_checked;
  int          val_errs;
  int          proto_errs;

  vit_dec i_vit_dec (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .isop    (isop),
    .ival    (ival),
    .ieop    (ieop),
    .isymb   (isymb),
    .osop    (osop),
    .oval    (oval),
    .oeop    (oeop),
    .odat    (odat),
    .obusy   (obusy)
  );

  always #CLK_HALF iclk = ~iclk;

  //--------------------------------------------------------------------------
  // random source
  //--------------------------------------------------------------------------

  // 16 bit galois shift, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic int rand_int(input int nbits);
    int v;
    v = 0;
    for (int i = 0; i < nbits; i++) begin
      v    = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
    rand_int = v;
  endfunction

  //--------------------------------------------------------------------------
  // checks and end of run
  //--------------------------------------------------------------------------

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      val_errs++;
      $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d protocol; %0d frames, %0d bits checked",
             val_errs, proto_errs, frame_idx, bits_checked);
    if (val_errs + proto_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  // one clock, returns whether the edge just passed was enabled
  // next enable is drawn here, 1 in 8 cycles low while stalling
  task automatic next_cycle(output logic took);
    int r;
    @(posedge iclk);
    took = iclkena;
    if (stall_on) begin
      r = rand_int(3);
      iclkena <= (r != 0);
    end else begin
      iclkena <= 1'b1;
    end
  endtask

  //--------------------------------------------------------------------------
  // output monitor, sampled mid cycle where oval and odat are stable
  //--------------------------------------------------------------------------

  always @(negedge iclk) begin : monitor
    logic e;
    if (run_checks) begin
      if (oval && !iclkena) begin
        proto_errs++;
        $display("output valid at %0d ns while clock enable was low", $time);
      end
      if (oval) begin
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("extra output bit at %0d ns outside any frame", $time);
        end else begin
          e = exp_q.pop_front();
          compare("odat", 32'(e), 32'(odat));
          compare("osop", 32'(out_cnt == 0), 32'(osop));
          compare("oeop", 32'(out_cnt == frame_bits - 1), 32'(oeop));
          compare("obusy", 32'd1, 32'(obusy));
          out_cnt++;
          bits_checked++;
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // one frame: encode, distort, drive, wait for the decoded bits
  //--------------------------------------------------------------------------

  task automatic run_frame(input int mode);
    int         n;
    int         r;
    int         p;
    int         cyc;
    logic       u;
    logic       s1;
    logic       s0;
    logic       took;
    logic [2:0] sv;
    n          = 3 + rand_int(6) % (FRAME_MAX - 2);
    frame_bits = n - TAIL_LEN;
    out_cnt    = 0;
    s1         = 1'b0;
    s0         = 1'b0;
    // encoder, state {u[n-1], u[n-2]}, g7 = u^s1^s0, g5 = u^s0
    for (int i = 0; i < n; i++) begin
      u = 1'b0;
      if (i < n - TAIL_LEN) begin
        r = rand_int(1);
        u = r[0];
        exp_q.push_back(u);
      end
      frame_sym[i] = {((u ^ s1 ^ s0) ? 3'd7 : 3'd0), ((u ^ s0) ? 3'd7 : 3'd0)};
      s0 = s1;
      s1 = u;
    end
    // one full flip anywhere in the frame
    if (mode == MODE_FLIP) begin
      p = rand_int(7) % (2 * n);
      frame_sym[p / 2][(p % 2) * 3 +: 3] = ~frame_sym[p / 2][(p % 2) * 3 +: 3];
    end
    // nudge each soft value at most one step toward the middle
    if (mode == MODE_NOISE) begin
      for (int i = 0; i < 2 * n; i++) begin
        r  = rand_int(1);
        sv = frame_sym[i / 2][(i % 2) * 3 +: 3];
        sv = (sv == 3'd0) ? 3'(r) : 3'd7 - 3'(r);
        frame_sym[i / 2][(i % 2) * 3 +: 3] = sv;
      end
    end
    // random unframed symbols stir up the path metrics before the sop restart
    for (int i = 0; i < PRE_SYMS; i++) begin
      isop  <= 1'b0;
      ieop  <= 1'b0;
      ival  <= 1'b1;
      isymb <= 6'(rand_int(6));
      took = 1'b0;
      while (!took) begin
        next_cycle(took);
      end
    end
    // each symbol is held until an enabled edge takes it
    for (int i = 0; i < n; i++) begin
      isop  <= (i == 0);
      ieop  <= (i == n - 1);
      ival  <= 1'b1;
      isymb <= frame_sym[i];
      took = 1'b0;
      while (!took) begin
        next_cycle(took);
      end
    end
    isop <= 1'b0;
    ieop <= 1'b0;
    ival <= 1'b0;
    cyc = 0;
    while ((out_cnt < frame_bits || obusy) && cyc < FRAME_WAIT) begin
      next_cycle(took);
      cyc++;
    end
    if (out_cnt < frame_bits) begin
      proto_errs++;
      $display("frame %0d: only %0d of %0d decoded bits came out", frame_idx, out_cnt,
               frame_bits);
    end else if (obusy) begin
      proto_errs++;
      $display("frame %0d: obusy never fell after the last output bit", frame_idx);
    end
    exp_q.delete();
    frame_idx++;
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------

  initial begin : main
    logic took;
    iclk         = 1'b0;
    ireset       = 1'b1;
    iclkena      = 1'b1;
    isop         = 1'b0;
    ival         = 1'b0;
    ieop         = 1'b0;
    isymb        = '0;
    lfsr         = 16'd7;
    stall_on     = 1'b0;
    run_checks   = 1'b0;
    frame_bits   = 0;
    out_cnt      = 0;
    frame_idx    = 0;
    bits_checked = 0;
    val_errs     = 0;
    proto_errs   = 0;
    repeat (RST_CYCLES) @(posedge iclk);
    ireset <= 1'b0;
    next_cycle(took);
    // quiet outputs before the first frame
    compare("oval", 32'd0, 32'(oval));
    compare("osop", 32'd0, 32'(osop));
    compare("oeop", 32'd0, 32'(oeop));
    compare("obusy", 32'd0, 32'(obusy));
    run_checks = 1'b1;
    // clean, single flip and small noise, first at full rate then stalled
    for (int ph = 0; ph < 6; ph++) begin
      stall_on = (ph >= 3);
      for (int f = 0; f < PHASE_FRAMES; f++) begin
        run_frame(ph % 3);
      end
    end
    stall_on = 1'b0;
    // catch trailing output
    repeat (10) next_cycle(took);
    finish_run();
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    proto_errs++;
    $display("watchdog expired after %0d cycles, decoder stopped responding",
             WATCHDOG_CYCLES);
    finish_run();
  end

endmodule

// File: sources.f
hdl/vit_trellis_pkg.sv
hdl/vit_dec_pkg.sv
hdl/vit_bm_if.sv
hdl/vit_dec_bmu.sv
hdl/vit_dec_acsu.sv
hdl/vit_dec_rp.sv
hdl/vit_dec_tbu.sv
hdl/vit_dec.sv
tests/vit_dec_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the viterbi decoder testbench with verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  -f sources.f \
  --top-module vit_dec_tb \
  --Mdir obj_dir \
  -o vit_dec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/vit_dec_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "simulation did not pass"
exit 1
